//--- source/niuIsaPkg.sv
package niuIsaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    localparam int InstrBytes = 4;  // PC step and immWord scale

    // Primary opcodes, reference encodings
    typedef enum logic [4:0] {
        opAluR = 5'b00000,
        opAddi = 5'b00001,
        opMlti = 5'b00010,
        opAndi = 5'b00101,
        opOri  = 5'b00110,
        opXori = 5'b00111,
        opSuli = 5'b01000,
        opSsli = 5'b01001,
        opSuri = 5'b01010,
        opSsri = 5'b01011,
        opLw   = 5'b10000,
        opSw   = 5'b10011,
        opBeq  = 5'b11000,
        opBne  = 5'b11001,
        opBlt  = 5'b11010,
        opBle  = 5'b11011,
        opJal  = 5'b11111
    } opcodeT;

    // Secondary codes, shared with immediate opcodes where the numbers match
    typedef enum logic [4:0] {
        fnSub = 5'b00000,
        fnAdd = 5'b00001,
        fnMlt = 5'b00010,
        fnNot = 5'b00100,
        fnAnd = 5'b00101,
        fnOr  = 5'b00110,
        fnXor = 5'b00111,
        fnSul = 5'b01000,
        fnSsl = 5'b01001,
        fnSur = 5'b01010,
        fnSsr = 5'b01011,
        fnEq  = 5'b10000,
        fnNeq = 5'b10001,
        fnLt  = 5'b10010,
        fnLeq = 5'b10011
    } aluFuncT;

    // Low 17 bits: rz on top, op2 at the bottom
    typedef struct packed {
        regIdxT     rz;
        logic [6:0] mid;
        aluFuncT    op2;
    } immFieldsT;

    typedef struct packed {
        opcodeT    op1;  // 31:27
        regIdxT    rx;   // 26:22
        regIdxT    ry;   // 21:17
        immFieldsT imm;  // 16:0
    } instrFieldsT;

    typedef enum logic [2:0] {
        busNone,
        busPc,
        busReg,
        busMem,
        busAlu,
        busImm,
        busImmWord  // Immediate times InstrBytes
    } busSrcT;

    typedef struct packed {
        busSrcT  busSrc;
        logic    ldPc;
        logic    incPc;
        logic    ldIr;
        logic    ldMar;
        logic    ldA;
        logic    ldB;
        logic    wrReg;
        logic    wrMem;
        regIdxT  regSel;
        aluFuncT aluFunc;
    } ctrlWordT;

endpackage

//--- source/niuHostPkg.sv
package niuHostPkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRespT;

    // Host address map
    localparam logic [15:0] ImemBase = 16'h0000;
    localparam logic [15:0] DmemBase = 16'h8000;
    localparam logic [15:0] CtrlAddr = 16'hF000;

    // Control register bits
    localparam int StartBit   = 0;  // Write side
    localparam int RunningBit = 0;  // Read side
    localparam int HaltedBit  = 1;

endpackage

//--- source/niuAlu.sv
`timescale 1ns/100ps

module niuAlu (
    input  niuIsaPkg::aluFuncT func,
    input  niuIsaPkg::wordT    a,
    input  niuIsaPkg::wordT    b,
    output niuIsaPkg::wordT    result
);
    import niuIsaPkg::*;

    logic signed [31:0] sa, sb;
    logic        [4:0]  shamt;

    assign sa    = $signed(a);
    assign sb    = $signed(b);
    assign shamt = b[4:0];  // Low five bits only

    always_comb begin
        case (func)
            fnSub:   result = sa - sb;
            fnAdd:   result = sa + sb;
            fnMlt:   result = sa * sb;  // Low word kept
            fnNot:   result = ~a;
            fnAnd:   result = a & b;
            fnOr:    result = a | b;
            fnXor:   result = a ^ b;
            fnSul:   result = a << shamt;
            fnSsl:   result = sa <<< shamt;
            fnSur:   result = a >> shamt;
            fnSsr:   result = sa >>> shamt;
            fnEq:    result = {31'b0, sa == sb};
            fnNeq:   result = {31'b0, sa != sb};
            fnLt:    result = {31'b0, sa < sb};
            fnLeq:   result = {31'b0, sa <= sb};
            default: result = '0;
        endcase
    end

endmodule

//--- source/niuRegFile.sv
`timescale 1ns/100ps

module niuRegFile (
    input  logic              clk,
    input  logic              reset,
    input  niuIsaPkg::regIdxT regSel,
    input  logic              wrReg,
    input  niuIsaPkg::wordT   wrData,
    output niuIsaPkg::wordT   rdData
);
    import niuIsaPkg::*;

    wordT regs [32];

    // Shared index, read is combinational
    assign rdData = regs[regSel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrReg) begin
            regs[regSel] <= wrData;
        end
    end

endmodule

//--- source/niuControl.sv
`timescale 1ns/100ps

module niuControl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  niuIsaPkg::instrFieldsT instr,
    input  niuIsaPkg::wordT        aluResult,
    output niuIsaPkg::ctrlWordT    ctrl,
    output logic                   running,
    output logic                   halted
);
    import niuIsaPkg::*;

    typedef enum logic [4:0] {
        stIdle, stFetch, stDecode,
        stAluB, stAluA, stAluWr,
        stLwA, stLwB, stLwMar, stLwRead, stLwWr,
        stSwA, stSwB, stSwMar, stSwWr,
        stBrA, stBrB, stBrCmp, stBrPc, stBrImm, stBrSum,
        stJalLink, stJalJump,
        stHalt
    } stateT;

    stateT   state, nextState;
    aluFuncT branchFunc;
    logic    isRegOp;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    assign running = (state != stIdle) && (state != stHalt);
    assign halted  = (state == stHalt);
    assign isRegOp = (instr.op1 == opAluR);

    always_comb begin
        case (instr.op1)
            opBeq:   branchFunc = fnEq;
            opBne:   branchFunc = fnNeq;
            opBlt:   branchFunc = fnLt;
            default: branchFunc = fnLeq;
        endcase
    end

    always_comb begin
        nextState   = state;
        ctrl        = '0;
        ctrl.busSrc = busNone;
        ctrl.aluFunc = fnAdd;  // Address and target arithmetic
        case (state)
            stIdle, stHalt: if (start) nextState = stFetch;
            stFetch: begin
                ctrl.ldIr  = 1'b1;
                ctrl.incPc = 1'b1;
                nextState  = stDecode;
            end
            stDecode: begin
                case (instr.op1)
                    opAluR, opAddi, opMlti, opAndi, opOri, opXori,
                    opSuli, opSsli, opSuri, opSsri: nextState = stAluB;
                    opLw:                           nextState = stLwA;
                    opSw:                           nextState = stSwA;
                    opBeq, opBne, opBlt, opBle:     nextState = stBrA;
                    opJal:                          nextState = stJalLink;
                    default:                        nextState = stHalt;
                endcase
            end
            stAluB: begin
                ctrl.busSrc = isRegOp ? busReg : busImm;
                ctrl.regSel = instr.ry;
                ctrl.ldB    = 1'b1;
                nextState   = stAluA;
            end
            stAluA, stLwA, stSwA, stBrA: begin
                ctrl.busSrc = busReg;
                ctrl.regSel = instr.rx;
                ctrl.ldA    = 1'b1;
                case (state)
                    stAluA:  nextState = stAluWr;
                    stLwA:   nextState = stLwB;
                    stSwA:   nextState = stSwB;
                    default: nextState = stBrB;
                endcase
            end
            stAluWr: begin
                ctrl.busSrc  = busAlu;
                ctrl.aluFunc = isRegOp ? instr.imm.op2 : aluFuncT'(instr.op1);
                ctrl.regSel  = isRegOp ? instr.imm.rz : instr.ry;  // rz for reg form
                ctrl.wrReg   = 1'b1;
                nextState    = stFetch;
            end
            stLwB, stSwB: begin
                ctrl.busSrc = busImm;
                ctrl.ldB    = 1'b1;
                nextState   = (state == stLwB) ? stLwMar : stSwMar;
            end
            stLwMar, stSwMar: begin
                ctrl.busSrc = busAlu;
                ctrl.ldMar  = 1'b1;
                nextState   = (state == stLwMar) ? stLwRead : stSwWr;
            end
            stLwRead: nextState = stLwWr;  // MDR follows MAR
            stLwWr: begin
                ctrl.busSrc = busMem;
                ctrl.regSel = instr.ry;
                ctrl.wrReg  = 1'b1;
                nextState   = stFetch;
            end
            stSwWr: begin
                ctrl.busSrc = busReg;
                ctrl.regSel = instr.ry;
                ctrl.wrMem  = 1'b1;
                nextState   = stFetch;
            end
            stBrB: begin
                ctrl.busSrc = busReg;
                ctrl.regSel = instr.ry;
                ctrl.ldB    = 1'b1;
                nextState   = stBrCmp;
            end
            stBrCmp: begin
                ctrl.aluFunc = branchFunc;
                nextState    = aluResult[0] ? stBrPc : stFetch;
            end
            stBrPc: begin
                ctrl.busSrc = busPc;  // Already incremented
                ctrl.ldA    = 1'b1;
                nextState   = stBrImm;
            end
            stBrImm: begin
                ctrl.busSrc = busImmWord;
                ctrl.ldB    = 1'b1;
                nextState   = stBrSum;
            end
            stBrSum: begin
                ctrl.busSrc = busAlu;
                ctrl.ldPc   = 1'b1;
                nextState   = stFetch;
            end
            stJalLink: begin
                ctrl.busSrc = busPc;
                ctrl.regSel = instr.ry;
                ctrl.wrReg  = 1'b1;
                nextState   = stJalJump;
            end
            stJalJump: begin
                ctrl.busSrc = busReg;
                ctrl.regSel = instr.rx;
                ctrl.ldPc   = 1'b1;
                nextState   = stFetch;
            end
            default: nextState = stHalt;
        endcase
    end

endmodule

//--- source/niuDatapath.sv
`timescale 1ns/100ps

module niuDatapath #(
    parameter niuIsaPkg::wordT resetPc = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  niuIsaPkg::ctrlWordT    ctrl,
    input  niuIsaPkg::wordT        instrWord,
    input  niuIsaPkg::wordT        memData,
    output niuIsaPkg::wordT        pc,
    output niuIsaPkg::wordT        mar,
    output niuIsaPkg::instrFieldsT instr,
    output niuIsaPkg::wordT        aluResult,
    output niuIsaPkg::wordT        storeData
);
    import niuIsaPkg::*;

    wordT bus, regData, immExt, aReg, bReg;

    assign immExt = {{15{instr.imm[16]}}, instr.imm};

    // One source per cycle
    always_comb begin
        case (ctrl.busSrc)
            busPc:      bus = pc;
            busReg:     bus = regData;
            busMem:     bus = memData;
            busAlu:     bus = aluResult;
            busImm:     bus = immExt;
            busImmWord: bus = immExt * InstrBytes;
            default:    bus = '0;
        endcase
    end

    assign storeData = bus;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= resetPc;
        end else if (start) begin
            pc <= resetPc;
        end else if (ctrl.ldPc) begin
            pc <= bus;
        end else if (ctrl.incPc) begin
            pc <= pc + InstrBytes;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ldIr) instr <= instrFieldsT'(instrWord);
        if (ctrl.ldA) aReg <= bus;
        if (ctrl.ldB) bReg <= bus;
        if (ctrl.ldMar) mar <= bus;
    end

    niuRegFile regFile (
        .clk    (clk),
        .reset  (reset),
        .regSel (ctrl.regSel),
        .wrReg  (ctrl.wrReg),
        .wrData (bus),
        .rdData (regData)
    );

    niuAlu alu (
        .func   (ctrl.aluFunc),
        .a      (aReg),
        .b      (bReg),
        .result (aluResult)
    );

endmodule

//--- source/niuMemorySystem.sv
`timescale 1ns/100ps

module niuMemorySystem #(
    parameter int imemWords = 1024,
    parameter int dmemWords = 1024
) (
    input  logic                 clk,
    input  logic                 reset,
    input  niuHostPkg::apbReqT   hostReq,
    output niuHostPkg::apbRespT  hostResp,
    input  niuIsaPkg::ctrlWordT  ctrl,
    input  niuIsaPkg::wordT      pc,
    input  niuIsaPkg::wordT      mar,
    input  niuIsaPkg::wordT      storeData,
    input  logic                 running,
    input  logic                 halted,
    output logic                 start,
    output niuIsaPkg::wordT      instrWord,
    output niuIsaPkg::wordT      memData
);
    import niuIsaPkg::*;
    import niuHostPkg::*;

    localparam int ImemAw = $clog2(imemWords);
    localparam int DmemAw = $clog2(dmemWords);

    wordT imem [imemWords];
    wordT dmem [dmemWords];
    wordT readData;
    logic setupPhase, accessPhase, inImem, inDmem, inCtrl, hostWrite;

    assign setupPhase  = hostReq.psel && !hostReq.penable;
    assign accessPhase = hostReq.psel && hostReq.penable;
    assign hostWrite   = accessPhase && hostReq.pwrite;

    // Window decode, byte addresses
    assign inImem = (int'(hostReq.paddr) >= int'(ImemBase)) &&
                    (int'(hostReq.paddr) < int'(ImemBase) + imemWords * 4);
    assign inDmem = (int'(hostReq.paddr) >= int'(DmemBase)) &&
                    (int'(hostReq.paddr) < int'(DmemBase) + dmemWords * 4);
    assign inCtrl = (hostReq.paddr == CtrlAddr);

    assign hostResp.prdata  = readData;
    assign hostResp.pready  = 1'b1;  // No wait states
    assign hostResp.pslverr = accessPhase &&
                              (((inImem || inDmem) && running) || !(inImem || inDmem || inCtrl));

    assign instrWord = imem[pc[ImemAw+1:2]];  // Core fetch path

    // Start pulse arrives the cycle after the control write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= hostWrite && inCtrl && hostReq.pwdata[StartBit] && !running;
        end
    end

    always_ff @(posedge clk) begin
        memData <= dmem[mar[DmemAw+1:2]];  // MDR tracks MAR every cycle
        if (ctrl.wrMem) begin
            dmem[mar[DmemAw+1:2]] <= storeData;
        end else if (hostWrite && inDmem && !running) begin
            dmem[hostReq.paddr[DmemAw+1:2]] <= hostReq.pwdata;
        end
        if (hostWrite && inImem && !running) imem[hostReq.paddr[ImemAw+1:2]] <= hostReq.pwdata;
        if (setupPhase) begin
            readData <= '0;
            if (inImem) readData <= imem[hostReq.paddr[ImemAw+1:2]];
            if (inDmem) readData <= dmem[hostReq.paddr[DmemAw+1:2]];
            if (inCtrl) begin
                readData[RunningBit] <= running;
                readData[HaltedBit]  <= halted;
            end
        end
    end

endmodule

//--- source/niuCpu.sv
`timescale 1ns/100ps

module niuCpu #(
    parameter int              imemWords = 1024,
    parameter int              dmemWords = 1024,
    parameter niuIsaPkg::wordT resetPc   = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  niuHostPkg::apbReqT  hostReq,
    output niuHostPkg::apbRespT hostResp
);
    import niuIsaPkg::*;

    ctrlWordT    ctrl;
    instrFieldsT instr;
    wordT        aluResult, pc, mar, storeData, instrWord, memData;
    logic        start, running, halted;

    niuControl control (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .instr     (instr),
        .aluResult (aluResult),
        .ctrl      (ctrl),
        .running   (running),
        .halted    (halted)
    );

    niuDatapath #(.resetPc(resetPc)) datapath (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .ctrl      (ctrl),
        .instrWord (instrWord),
        .memData   (memData),
        .pc        (pc),
        .mar       (mar),
        .instr     (instr),
        .aluResult (aluResult),
        .storeData (storeData)
    );

    niuMemorySystem #(.imemWords(imemWords), .dmemWords(dmemWords)) memory (
        .clk       (clk),
        .reset     (reset),
        .hostReq   (hostReq),
        .hostResp  (hostResp),
        .ctrl      (ctrl),
        .pc        (pc),
        .mar       (mar),
        .storeData (storeData),
        .running   (running),
        .halted    (halted),
        .start     (start),
        .instrWord (instrWord),
        .memData   (memData)
    );

endmodule

//--- sim/niuCpuTb.sv
`timescale 1ns/100ps

module niuCpuTb;
    import niuIsaPkg::*;
    import niuHostPkg::*;

    localparam int   RunLimit    = 400;    // ALU program needs about 300 cycles
    localparam int   GlobalLimit = 20000;  // All five tests need well under 3000
    localparam wordT HaltWord    = {5'b00100, 27'b0};  // Undefined opcode

    // One range of data memory result slots per test
    localparam int AluSlot    = 16;
    localparam int DataSlot   = 48;
    localparam int BranchSlot = 60;
    localparam int HaltSlot   = 70;

    logic    clk;
    logic    reset;
    apbReqT  hostReq;
    apbRespT hostResp;

    int   cycleCount = 0;
    int   checkCount = 0;
    int   errorCount = 0;
    wordT seedValue;
    wordT prog [$];
    int   slots [$];
    wordT results [$];

    niuCpu #(
        .imemWords (1024),
        .dmemWords (1024),
        .resetPc   (32'h0)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .hostReq  (hostReq),
        .hostResp (hostResp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= GlobalLimit) begin
            $display("Timeout: simulation reached %0d cycles", GlobalLimit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic checkValue(string name, wordT actual, wordT expectedValue);
        checkCount++;
        if (actual !== expectedValue) begin
            $display("** Error %s: got %h, expected %h", name, actual, expectedValue);
            errorCount++;
        end
    endtask

    task automatic reportTest(string name, int errStart);
        if (errorCount == errStart) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errorCount - errStart);
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
    endtask

    // Setup, access, then one idle cycle
    task automatic apbWrite(input logic [15:0] addr, input wordT data, output logic err);
        @(negedge clk);
        hostReq.psel    = 1'b1;
        hostReq.penable = 1'b0;
        hostReq.pwrite  = 1'b1;
        hostReq.paddr   = addr;
        hostReq.pwdata  = data;
        @(negedge clk);
        hostReq.penable = 1'b1;
        #1;
        err = hostResp.pslverr;
        checkValue("pready", hostResp.pready, 32'h1);  // No wait states
        @(negedge clk);
        hostReq = '0;
    endtask

    task automatic apbRead(input logic [15:0] addr, output wordT data, output logic err);
        @(negedge clk);
        hostReq.psel    = 1'b1;
        hostReq.penable = 1'b0;
        hostReq.pwrite  = 1'b0;
        hostReq.paddr   = addr;
        hostReq.pwdata  = '0;
        @(negedge clk);
        hostReq.penable = 1'b1;
        #1;
        data = hostResp.prdata;  // Valid in the access cycle
        err  = hostResp.pslverr;
        checkValue("pready", hostResp.pready, 32'h1);
        @(negedge clk);
        hostReq = '0;
    endtask

    task automatic writeNoError(logic [15:0] addr, wordT data);
        logic err;
        apbWrite(addr, data, err);
        checkValue($sformatf("pslverr at %h", addr), err, 32'h0);
    endtask

    task automatic readNoError(input logic [15:0] addr, output wordT data);
        logic err;
        apbRead(addr, data, err);
        checkValue($sformatf("pslverr at %h", addr), err, 32'h0);
    endtask

    function automatic logic [15:0] dmemAddr(int slot);
        return 16'(DmemBase + slot * 4);
    endfunction

    // One instruction encoder per format
    function automatic wordT encReg(aluFuncT func, regIdxT rz, regIdxT rx, regIdxT ry);
        return {opAluR, rx, ry, rz, 7'b0, func};
    endfunction

    function automatic wordT encImm(opcodeT op, regIdxT ry, regIdxT rx, int imm);
        return {op, rx, ry, 17'(imm)};
    endfunction

    function automatic wordT encBranch(opcodeT op, regIdxT rx, regIdxT ry, int offset);
        return {op, rx, ry, 17'(offset)};  // Offset in words from PC + 4
    endfunction

    function automatic wordT encJal(regIdxT ry, regIdxT rx);
        return {opJal, rx, ry, 17'b0};
    endfunction

    function automatic wordT swToSlot(regIdxT rs, int slot);
        return encImm(opSw, rs, 5'd0, slot * 4);
    endfunction

    // Reference results for each ALU function
    function automatic wordT aluModel(aluFuncT func, wordT a, wordT b);
        logic [4:0] sh;
        sh = b[4:0];
        case (func)
            fnSub:        return a - b;
            fnAdd:        return a + b;
            fnMlt:        return a * b;  // Low word is the same for signed
            fnNot:        return ~a;
            fnAnd:        return a & b;
            fnOr:         return a | b;
            fnXor:        return a ^ b;
            fnSul, fnSsl: return a << sh;
            fnSur:        return a >> sh;
            fnSsr:        return wordT'($signed(a) >>> sh);
            fnEq:         return wordT'(a == b);
            fnNeq:        return wordT'(a != b);
            fnLt:         return wordT'($signed(a) < $signed(b));
            fnLeq:        return wordT'($signed(a) <= $signed(b));
            default:      return '0;
        endcase
    endfunction

    function automatic aluFuncT immFunc(opcodeT op);
        case (op)
            opAddi:  return fnAdd;
            opMlti:  return fnMlt;
            opAndi:  return fnAnd;
            opOri:   return fnOr;
            opXori:  return fnXor;
            opSuli:  return fnSul;
            opSsli:  return fnSsl;
            opSuri:  return fnSur;
            default: return fnSsr;
        endcase
    endfunction

    // Full word from upper half, shift and lower half
    task automatic loadConst(regIdxT rd, wordT value);
        prog.push_back(encImm(opAddi, rd, 5'd0, int'(value[31:16])));
        prog.push_back(encImm(opSuli, rd, rd, 16));
        prog.push_back(encImm(opOri, rd, rd, int'(value[15:0])));
    endtask

    task automatic expectSlot(int slot, wordT value);
        slots.push_back(slot);
        results.push_back(value);
    endtask

    task automatic checkSlots();
        wordT readBack;
        foreach (slots[i]) begin
            readNoError(dmemAddr(slots[i]), readBack);
            checkValue($sformatf("dmem[%0d]", slots[i]), readBack, results[i]);
        end
        slots.delete();
        results.delete();
    endtask

    task automatic loadProgram();
        foreach (prog[i]) begin
            writeNoError(16'(ImemBase + i * 4), prog[i]);
        end
    endtask

    task automatic runProgram();
        wordT status;
        int   startCycle;
        writeNoError(CtrlAddr, 32'h1);
        startCycle = cycleCount;
        status     = '0;
        while (!status[HaltedBit] && (cycleCount - startCycle) < RunLimit) begin
            readNoError(CtrlAddr, status);
        end
        if (!status[HaltedBit]) begin
            $display("runProgram: processor did not halt within %0d cycles", RunLimit);
            errorCount++;
        end
    endtask

    task automatic hostAccess();
        int   errStart;
        wordT data [8];
        wordT readBack;
        logic err;
        errStart = errorCount;
        foreach (data[i]) begin
            data[i] = $urandom;
            writeNoError(dmemAddr(i), data[i]);
        end
        foreach (data[i]) begin
            readNoError(dmemAddr(i), readBack);
            checkValue($sformatf("dmem[%0d]", i), readBack, data[i]);
        end
        readNoError(CtrlAddr, readBack);
        checkValue("status", readBack, 32'h0);  // Idle after reset
        apbRead(16'h4000, readBack, err);  // Outside every window
        checkValue("pslverr at 4000", err, 32'h1);
        apbWrite(16'hF004, 32'h1, err);
        checkValue("pslverr at f004", err, 32'h1);
        reportTest("hostAccess", errStart);
    endtask

    task automatic aluOps();
        aluFuncT     regFuncs [15] = '{fnSub, fnAdd, fnMlt, fnNot, fnAnd, fnOr, fnXor,
                                       fnSul, fnSsl, fnSur, fnSsr, fnEq, fnNeq, fnLt, fnLeq};
        opcodeT      immOps [9] = '{opAddi, opMlti, opAndi, opOri, opXori,
                                    opSuli, opSsli, opSuri, opSsri};
        int          errStart;
        wordT        a, b;
        logic [16:0] immBits;
        errStart = errorCount;
        a = $urandom;
        b = $urandom;
        prog.delete();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        foreach (regFuncs[i]) begin
            prog.push_back(encReg(regFuncs[i], 5'd3, 5'd1, 5'd2));
            prog.push_back(swToSlot(5'd3, AluSlot + i));
            expectSlot(AluSlot + i, aluModel(regFuncs[i], a, b));
        end
        foreach (immOps[i]) begin
            immBits = 17'($urandom);
            prog.push_back(encImm(immOps[i], 5'd4, 5'd1, int'(immBits)));
            prog.push_back(swToSlot(5'd4, AluSlot + 15 + i));
            expectSlot(AluSlot + 15 + i,
                       aluModel(immFunc(immOps[i]), a, {{15{immBits[16]}}, immBits}));
        end
        prog.push_back(HaltWord);
        loadProgram();
        runProgram();
        checkSlots();
        reportTest("aluOps", errStart);
    endtask

    task automatic loadStore();
        int   errStart;
        wordT words [4];
        errStart = errorCount;
        foreach (words[i]) begin
            words[i] = $urandom;
            writeNoError(dmemAddr(DataSlot + i), words[i]);
        end
        writeNoError(dmemAddr(DataSlot - 1), 32'hDEADBEEF);
        writeNoError(dmemAddr(DataSlot + 6), 32'hDEADBEEF);
        prog.delete();
        prog.push_back(encImm(opAddi, 5'd6, 5'd0, (DataSlot + 2) * 4));  // Base in the middle
        prog.push_back(encImm(opLw, 5'd7, 5'd6, -8));
        prog.push_back(encImm(opLw, 5'd8, 5'd6, -4));
        prog.push_back(encImm(opLw, 5'd9, 5'd6, 0));
        prog.push_back(encImm(opLw, 5'd10, 5'd6, 4));
        prog.push_back(encReg(fnAdd, 5'd11, 5'd7, 5'd8));
        prog.push_back(encReg(fnAdd, 5'd11, 5'd11, 5'd9));
        prog.push_back(encReg(fnAdd, 5'd11, 5'd11, 5'd10));
        prog.push_back(encImm(opSw, 5'd11, 5'd6, 16));
        prog.push_back(encImm(opSw, 5'd7, 5'd6, -12));
        prog.push_back(HaltWord);
        expectSlot(DataSlot + 6, words[0] + words[1] + words[2] + words[3]);
        expectSlot(DataSlot - 1, words[0]);
        loadProgram();
        runProgram();
        checkSlots();
        reportTest("loadStore", errStart);
    endtask

    // Stores 2 when the branch is taken and 1 when it falls through
    task automatic branchCase(opcodeT op, regIdxT rx, int xv, regIdxT ry, int yv, int slot);
        logic taken;
        case (op)
            opBeq:   taken = (xv == yv);
            opBne:   taken = (xv != yv);
            opBlt:   taken = (xv < yv);
            default: taken = (xv <= yv);
        endcase
        prog.push_back(encBranch(op, rx, ry, 2));
        prog.push_back(encImm(opAddi, 5'd12, 5'd0, 1));
        prog.push_back(encBranch(opBeq, 5'd0, 5'd0, 1));
        prog.push_back(encImm(opAddi, 5'd12, 5'd0, 2));
        prog.push_back(swToSlot(5'd12, slot));
        expectSlot(slot, taken ? 32'd2 : 32'd1);
    endtask

    task automatic branchesAndJal();
        int errStart;
        int loopCount;
        int jalIndex;
        errStart  = errorCount;
        loopCount = 5;
        writeNoError(dmemAddr(BranchSlot + 8), 32'hFFFFFFFF);
        prog.delete();
        prog.push_back(encImm(opAddi, 5'd1, 5'd0, loopCount));
        prog.push_back(encImm(opAddi, 5'd2, 5'd0, 0));
        prog.push_back(encImm(opAddi, 5'd2, 5'd2, 1));  // Loop body
        prog.push_back(encImm(opAddi, 5'd1, 5'd1, -1));
        prog.push_back(encBranch(opBne, 5'd1, 5'd0, -3));
        prog.push_back(swToSlot(5'd2, BranchSlot));
        prog.push_back(swToSlot(5'd1, BranchSlot + 1));
        expectSlot(BranchSlot, loopCount);
        expectSlot(BranchSlot + 1, 32'd0);
        prog.push_back(encImm(opAddi, 5'd3, 5'd0, -3));
        prog.push_back(encImm(opAddi, 5'd4, 5'd0, 7));
        prog.push_back(encImm(opAddi, 5'd5, 5'd0, 7));
        branchCase(opBeq, 5'd4, 7, 5'd5, 7, BranchSlot + 2);
        branchCase(opBeq, 5'd3, -3, 5'd4, 7, BranchSlot + 3);
        branchCase(opBlt, 5'd3, -3, 5'd4, 7, BranchSlot + 4);
        branchCase(opBlt, 5'd4, 7, 5'd3, -3, BranchSlot + 5);
        branchCase(opBle, 5'd4, 7, 5'd5, 7, BranchSlot + 6);
        branchCase(opBle, 5'd4, 7, 5'd3, -3, BranchSlot + 7);
        // Target sits two words past the JAL with a halt in between
        jalIndex = prog.size() + 1;
        prog.push_back(encImm(opAddi, 5'd13, 5'd0, (jalIndex + 2) * 4));
        prog.push_back(encJal(5'd15, 5'd13));
        prog.push_back(HaltWord);
        prog.push_back(swToSlot(5'd15, BranchSlot + 8));
        prog.push_back(HaltWord);
        expectSlot(BranchSlot + 8, jalIndex * 4 + 4);
        loadProgram();
        runProgram();
        checkSlots();
        reportTest("branchesAndJal", errStart);
    endtask

    task automatic haltAndLockout();
        int   errStart;
        wordT readBack;
        logic err;
        errStart = errorCount;
        writeNoError(dmemAddr(HaltSlot), 32'h0);
        prog.delete();
        prog.push_back(encImm(opAddi, 5'd1, 5'd0, 9));
        prog.push_back(swToSlot(5'd1, HaltSlot));
        prog.push_back(HaltWord);
        expectSlot(HaltSlot, 32'd9);
        loadProgram();
        runProgram();
        readNoError(CtrlAddr, readBack);
        checkValue("status", readBack, 32'h2);  // Halted and not running
        checkSlots();

        // Endless loop keeps the core busy
        prog.delete();
        prog.push_back(encImm(opAddi, 5'd5, 5'd0, 32'h55));
        prog.push_back(encBranch(opBeq, 5'd0, 5'd0, -1));
        loadProgram();
        writeNoError(CtrlAddr, 32'h1);
        readNoError(CtrlAddr, readBack);
        checkValue("status", readBack, 32'h1);
        apbRead(dmemAddr(HaltSlot), readBack, err);
        checkValue("pslverr on dmem read", err, 32'h1);
        apbWrite(ImemBase, HaltWord, err);
        checkValue("pslverr on imem write", err, 32'h1);
        readNoError(CtrlAddr, readBack);
        checkValue("status", readBack, 32'h1);

        applyReset();
        readNoError(CtrlAddr, readBack);
        checkValue("status", readBack, 32'h0);
        writeNoError(dmemAddr(HaltSlot + 1), 32'hFFFFFFFF);
        writeNoError(dmemAddr(HaltSlot + 2), 32'h0);
        prog.delete();
        prog.push_back(swToSlot(5'd5, HaltSlot + 1));  // r5 cleared by reset
        prog.push_back(encImm(opAddi, 5'd6, 5'd0, 32'h77));
        prog.push_back(swToSlot(5'd6, HaltSlot + 2));
        prog.push_back(HaltWord);
        expectSlot(HaltSlot + 1, 32'h0);
        expectSlot(HaltSlot + 2, 32'h77);
        loadProgram();
        runProgram();
        checkSlots();
        reportTest("haltAndLockout", errStart);
    endtask

    initial begin
        seedValue = $urandom(32'h942f);
        hostReq   = '0;
        reset     = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        hostAccess();
        aluOps();
        loadStore();
        branchesAndJal();
        haltAndLockout();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- niuCpu.f
source/niuIsaPkg.sv
source/niuHostPkg.sv
source/niuAlu.sv
source/niuRegFile.sv
source/niuControl.sv
source/niuDatapath.sv
source/niuMemorySystem.sv
source/niuCpu.sv
sim/niuCpuTb.sv

//--- Bender.yml
package:
  name: niuCpu

sources:
  - source/niuIsaPkg.sv
  - source/niuHostPkg.sv
  - source/niuAlu.sv
  - source/niuRegFile.sv
  - source/niuControl.sv
  - source/niuDatapath.sv
  - source/niuMemorySystem.sv
  - source/niuCpu.sv
  - target: test
    files:
      - sim/niuCpuTb.sv
